// File: filelist.f
+incdir+source
source/ucode_mon_pkg.sv
source/ucode_class_if.sv
source/ucode_field_decode.sv
source/cycle_rule_check.sv
source/stage_rule_check.sv
source/reg_change_check.sv
source/ucode_mon_ctrl.sv
source/ucode_monitor.sv
testbench/ucode_monitor_tb.sv

// File: run.sh
#!/bin/sh
# build the monitor and its testbench with Verilator, run it, look for the pass line
verilator --binary --timing -j 0 -f filelist.f --top-module ucode_monitor_tb -Mdir obj_dir &&
	./obj_dir/Vucode_monitor_tb | tee /dev/stderr | grep -F "All tests passed" > /dev/null &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// File: testbench/ucode_monitor_tb.sv
/*
 ucode monitor testbench
 LFSR-driven microcode traffic, checked cycle by cycle against a rule model
*/
`timescale 1ns/1ps
`include "ucode_mon_settings.svh"

module ucode_monitor_tb;

	localparam int N_CYCLES = 2000;
	// fixed upper address bits so that the 2 random low bits collide often
	localparam logic [`UM_ADDR_W-3:0] ADDR_HI = 'h2b3c;
	// rule number per record bit with rule 1 in bit 0
	localparam int RULE_NUM [8] = '{1, 4, 5, 7, 8, 9, 14, 15};

	logic clk;
	logic rst;
	logic mon_en;
	logic [2:0] u_f01;
	logic [1:0] u_f02;
	logic [1:0] u_f03;
	logic [2:0] u_f05;
	logic [`UM_ADDR_W-1:0] addr_st_wt;
	logic [`UM_ADDR_W-1:0] addr_st_rd;
	logic u_exception;
	logic ie_stall_ucode;
	logic u_last;
	logic u_done;
	logic iu_trap_r;
	logic ifu_op_valid_r;
	logic u_ref_null_c;
	logic u_ary_ovf_c;
	logic gc_trap_c;
	logic u_ptr_un_eq_c;
	logic nxt_ucode_last;
	logic reg_enable;
	logic [`UM_REG_W-1:0] vars;
	logic [`UM_REG_W-1:0] frame;
	logic [`UM_REG_W-1:0] cp;
	logic err_valid;
	logic [3:0] err_rule;
	logic [`UM_RULE_CNT-1:0] err_seen;

	// model state for the E/C/W history and the rule 15 tracker
	logic [31:0] lfsr;
	logic acc_c_m;
	logic flag_w_m;
	logic last_m;
	logic armed_m;
	logic changed_m;
	logic [`UM_REG_W-1:0] snap_vars;
	logic [`UM_REG_W-1:0] snap_frame;
	logic [`UM_REG_W-1:0] snap_cp;
	// expected registered outputs
	logic exp_valid;
	logic [3:0] exp_rule;
	logic [7:0] exp_seen;
	int hit_cnt [8];
	int masked_cnt;
	int cyc;
	logic cov_ok;

	ucode_monitor dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog sized from the test length plus margin
	initial begin
		#((N_CYCLES + 100) * 10);
		$display("watchdog expired before the test loop finished");
		$display("Some tests failed");
		$fatal(1);
	end

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s at cycle %0d: got 0x%0h expected 0x%0h",
				name, cyc, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs();
		check_eq("err_valid", 32'(err_valid), 32'(exp_valid));
		check_eq("err_rule", 32'(err_rule), 32'(exp_rule));
		check_eq("err_seen", 32'(err_seen), 32'(exp_seen));
	endtask

	// traffic during reset breaks rules 1, 8 and 14 and loads every pipeline stage
	task automatic reset_inputs();
		rst = 1'b1;
		mon_en = 1'b1;
		u_f01 = 3'd1;
		u_f02 = 2'd1;
		u_f03 = 2'd1;
		u_f05 = 3'd3;
		addr_st_wt = '0;
		addr_st_rd = '0;
		{u_exception, ie_stall_ucode, u_done} = '0;
		u_last = 1'b1;
		{iu_trap_r, ifu_op_valid_r, nxt_ucode_last, reg_enable} = '1;
		{u_ref_null_c, u_ary_ovf_c, gc_trap_c, u_ptr_un_eq_c} = '1;
		vars = 32'h0000_1000;
		frame = 32'h0000_2000;
		cp = 32'h0000_3000;
	endtask

	task automatic drive_inputs();
		// mon_en low about 1 in 16
		mon_en = (take_bits(4) != 0);
		// stack writes in about a quarter of cycles
		if (take_bits(2) == 0)
			u_f01 = 3'(take_bits(3));
		else
			u_f01 = 3'd0;
		if (take_bits(1) == 0)
			u_f02 = 2'(take_bits(2));
		else
			u_f02 = 2'd0;
		u_f03 = 2'(take_bits(2));
		u_f05 = 3'(take_bits(3));
		addr_st_wt = {ADDR_HI, 2'(take_bits(2))};
		addr_st_rd = {ADDR_HI, 2'(take_bits(2))};
		u_exception = (take_bits(3) == 0);
		ie_stall_ucode = (take_bits(2) == 0);
		u_last = (take_bits(3) == 0);
		u_done = (take_bits(3) == 0);
		iu_trap_r = (take_bits(3) == 0);
		ifu_op_valid_r = (take_bits(1) != 0);
		u_ref_null_c = (take_bits(3) == 0);
		u_ary_ovf_c = (take_bits(3) == 0);
		gc_trap_c = (take_bits(3) == 0);
		u_ptr_un_eq_c = (take_bits(3) == 0);
		nxt_ucode_last = (take_bits(2) == 0);
		reg_enable = (take_bits(1) != 0);
		// base registers move about 1 in 8 and always to a new value
		if (take_bits(3) == 0)
			vars = vars + take_bits(8) + 32'd1;
		if (take_bits(3) == 0)
			frame = frame + take_bits(8) + 32'd1;
		if (take_bits(3) == 0)
			cp = cp + take_bits(8) + 32'd1;
	endtask

	// one clock of the rule model on the inputs just driven
	task automatic step_model();
		logic wt_stk;
		logic rd_stk;
		logic special;
		logic dc_read;
		logic dc_acc;
		logic optop_wr;
		logic vars_wr;
		logic base_wr;
		logic exc_c;
		logic [7:0] viol;
		logic [7:0] masked;
		// access classes from the field encodings
		wt_stk = (u_f01 != 3'd0);
		rd_stk = (u_f02 != 2'd0);
		special = (u_f01 == 3'd2) || (u_f01 == 3'd3);
		dc_read = (u_f03 == 2'd1) || (u_f03 == 2'd3);
		dc_acc = (u_f03 != 2'd0);
		optop_wr = (u_f05 == 3'd1) || (u_f05 == 3'd2);
		vars_wr = (u_f05 == 3'd3);
		base_wr = (u_f05 >= 3'd3) && (u_f05 <= 3'd5);
		exc_c = u_ref_null_c | u_ary_ovf_c | gc_trap_c | u_ptr_un_eq_c;
		viol = '0;
		viol[0] = wt_stk & rd_stk & (addr_st_wt == addr_st_rd);
		viol[1] = special & ~dc_read;
		// access two cycles back with an exception last cycle and no done now
		viol[2] = flag_w_m & ~u_done;
		viol[3] = ie_stall_ucode & u_exception;
		viol[4] = u_last & ~u_done;
		viol[5] = last_m & (optop_wr | vars_wr);
		viol[6] = iu_trap_r & ifu_op_valid_r;
		// done ends the rule 15 sequence
		if (u_done) begin
			armed_m = 1'b0;
			changed_m = 1'b0;
		end else begin
			if (base_wr) begin
				snap_vars = vars;
				snap_frame = frame;
				snap_cp = cp;
				armed_m = 1'b1;
			end else if (armed_m && (vars != snap_vars || frame != snap_frame ||
				cp != snap_cp)) begin
				changed_m = 1'b1;
			end
			viol[7] = armed_m & changed_m & dc_read;
		end
		// advance E to C to W
		flag_w_m = acc_c_m & exc_c;
		acc_c_m = wt_stk | rd_stk | dc_acc;
		last_m = nxt_ucode_last & reg_enable & ~u_exception;
		masked = mon_en ? viol : 8'h00;
		if (!mon_en && viol != 8'h00)
			masked_cnt++;
		exp_valid = (masked != 8'h00);
		exp_rule = 4'd0;
		// lowest rule wins
		for (int i = 7; i >= 0; i--) begin
			if (masked[i]) begin
				exp_rule = 4'(RULE_NUM[i]);
				hit_cnt[i]++;
			end
		end
		exp_seen = exp_seen | masked;
	endtask

	initial begin
		lfsr = 32'hc95d;
		{acc_c_m, flag_w_m, last_m, armed_m, changed_m} = '0;
		{snap_vars, snap_frame, snap_cp} = '0;
		exp_valid = 1'b0;
		exp_rule = 4'd0;
		exp_seen = 8'h00;
		masked_cnt = 0;
		cyc = 0;
		foreach (hit_cnt[i])
			hit_cnt[i] = 0;
		reset_inputs();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// reset must have cleared everything the traffic above loaded
		check_outputs();
		for (cyc = 0; cyc < N_CYCLES; cyc++) begin
			drive_inputs();
			step_model();
			@(negedge clk);
			check_outputs();
		end
		cov_ok = 1'b1;
		for (int i = 0; i < 8; i++) begin
			if (hit_cnt[i] == 0) begin
				$display("rule %0d was never raised by the random traffic", RULE_NUM[i]);
				cov_ok = 1'b0;
			end
		end
		if (masked_cnt == 0) begin
			$display("no violation ever fell in a cycle with mon_en low");
			cov_ok = 1'b0;
		end
		if (!cov_ok) begin
			$display("Some tests failed");
			$fatal(1);
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: source/ucode_monitor.sv
/*
 microcode sequencer monitor, top level
 decodes fields, runs the rule checkers and reports the first failing rule
*/
`timescale 1ns/1ps
`include "ucode_mon_settings.svh"

module ucode_monitor (
	input logic clk,
	input logic rst,
	input logic mon_en,
	input logic [2:0] u_f01,
	input logic [1:0] u_f02,
	input logic [1:0] u_f03,
	input logic [2:0] u_f05,
	input logic [`UM_ADDR_W-1:0] addr_st_wt,
	input logic [`UM_ADDR_W-1:0] addr_st_rd,
	input logic u_exception,
	input logic ie_stall_ucode,
	input logic u_last,
	input logic u_done,
	input logic iu_trap_r,
	input logic ifu_op_valid_r,
	input logic u_ref_null_c,
	input logic u_ary_ovf_c,
	input logic gc_trap_c,
	input logic u_ptr_un_eq_c,
	input logic nxt_ucode_last,
	input logic reg_enable,
	input logic [`UM_REG_W-1:0] vars,
	input logic [`UM_REG_W-1:0] frame,
	input logic [`UM_REG_W-1:0] cp,
	output logic err_valid,
	output logic [3:0] err_rule,
	output logic [`UM_RULE_CNT-1:0] err_seen
);

	ucode_mon_pkg::f01_t f01;
	ucode_mon_pkg::f02_t f02;
	ucode_mon_pkg::f03_t f03;
	ucode_mon_pkg::f05_t f05;
	ucode_mon_pkg::rule_vec_t viol_cycle;
	ucode_mon_pkg::rule_vec_t viol_stage;
	ucode_mon_pkg::rule_vec_t viol_reg;
	ucode_mon_pkg::rule_t rule_q;
	ucode_mon_pkg::rule_vec_t seen_q;

	// raw fields onto the encodings, unnamed values pass through
	assign f01 = ucode_mon_pkg::f01_t'(u_f01);
	assign f02 = ucode_mon_pkg::f02_t'(u_f02);
	assign f03 = ucode_mon_pkg::f03_t'(u_f03);
	assign f05 = ucode_mon_pkg::f05_t'(u_f05);

	ucode_class_if cls_if ();

	ucode_field_decode u_decode (
		.u_f01(f01),
		.u_f02(f02),
		.u_f03(f03),
		.u_f05(f05),
		.cls(cls_if.decode)
	);

	cycle_rule_check u_cycle (
		.cls(cls_if.check),
		.addr_st_wt(addr_st_wt),
		.addr_st_rd(addr_st_rd),
		.u_exception(u_exception),
		.ie_stall_ucode(ie_stall_ucode),
		.u_last(u_last),
		.u_done(u_done),
		.iu_trap_r(iu_trap_r),
		.ifu_op_valid_r(ifu_op_valid_r),
		.viol(viol_cycle)
	);

	stage_rule_check u_stage (
		.clk(clk),
		.rst(rst),
		.cls(cls_if.check),
		.u_ref_null_c(u_ref_null_c),
		.u_ary_ovf_c(u_ary_ovf_c),
		.gc_trap_c(gc_trap_c),
		.u_ptr_un_eq_c(u_ptr_un_eq_c),
		.u_done(u_done),
		.nxt_ucode_last(nxt_ucode_last),
		.reg_enable(reg_enable),
		.u_exception(u_exception),
		.viol(viol_stage)
	);

	reg_change_check u_reg (
		.clk(clk),
		.rst(rst),
		.cls(cls_if.check),
		.u_done(u_done),
		.vars(vars),
		.frame(frame),
		.cp(cp),
		.viol(viol_reg)
	);

	ucode_mon_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.mon_en(mon_en),
		.viol_cycle(viol_cycle),
		.viol_stage(viol_stage),
		.viol_reg(viol_reg),
		.err_valid(err_valid),
		.err_rule(rule_q),
		.err_seen(seen_q)
	);

	// plain vectors at the boundary
	assign err_rule = rule_q;
	assign err_seen = seen_q;

endmodule

// File: source/ucode_mon_ctrl.sv
/*
 monitor control
 enable masking, lowest-rule pick, error strobe and sticky record
*/
`timescale 1ns/1ps
`include "ucode_mon_settings.svh"

module ucode_mon_ctrl (
	input logic clk,
	input logic rst,
	input logic mon_en,
	input ucode_mon_pkg::rule_vec_t viol_cycle,
	input ucode_mon_pkg::rule_vec_t viol_stage,
	input ucode_mon_pkg::rule_vec_t viol_reg,
	output logic err_valid,
	output ucode_mon_pkg::rule_t err_rule,
	output ucode_mon_pkg::rule_vec_t err_seen
);

	logic [`UM_RULE_CNT-1:0] viol_bits;
	ucode_mon_pkg::rule_t first;

	// record bit index to rule number
	function automatic ucode_mon_pkg::rule_t rule_code(input int idx);
		case (idx)
			0: return ucode_mon_pkg::SAME_ADDR;
			1: return ucode_mon_pkg::SPECIAL_RD;
			2: return ucode_mon_pkg::EXC_DONE;
			3: return ucode_mon_pkg::STALL_EXC;
			4: return ucode_mon_pkg::LAST_DONE;
			5: return ucode_mon_pkg::LAST_REG;
			6: return ucode_mon_pkg::TRAP_OP;
			7: return ucode_mon_pkg::REG_READ;
			default: return ucode_mon_pkg::NONE;
		endcase
	endfunction

	// checkers own disjoint bits, mon_en masks the whole cycle
	assign viol_bits = (viol_cycle | viol_stage | viol_reg) & {`UM_RULE_CNT{mon_en}};

	// scan downwards so the lowest rule wins
	always_comb begin
		first = ucode_mon_pkg::NONE;
		for (int i = `UM_RULE_CNT - 1; i >= 0; i--) begin
			if (viol_bits[i])
				first = rule_code(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			err_valid <= 1'b0;
			err_rule <= ucode_mon_pkg::NONE;
			err_seen <= '0;
		end else begin
			err_valid <= |viol_bits;
			err_rule <= first;
			// sticky until reset
			err_seen <= err_seen | viol_bits;
		end
	end

	// strobe always carries a rule
	a_valid_rule: assert property (@(posedge clk) disable iff (rst)
		err_valid |-> err_rule != ucode_mon_pkg::NONE);

endmodule

// File: source/reg_change_check.sv
/*
 rule 15 tracker
 snapshots vars, frame and cp on base writes and flags later d$ reads
*/
`timescale 1ns/1ps
`include "ucode_mon_settings.svh"

module reg_change_check (
	input logic clk,
	input logic rst,
	ucode_class_if.check cls,
	input logic u_done,
	input logic [`UM_REG_W-1:0] vars,
	input logic [`UM_REG_W-1:0] frame,
	input logic [`UM_REG_W-1:0] cp,
	output ucode_mon_pkg::rule_vec_t viol
);

	logic armed_q;
	logic changed_q;
	logic [`UM_REG_W-1:0] vars_snap;
	logic [`UM_REG_W-1:0] frame_snap;
	logic [`UM_REG_W-1:0] cp_snap;
	logic armed_now;
	logic diff;
	logic changed_now;

	// base write this cycle arms at once
	assign armed_now = armed_q | cls.base_wr;

	// a fresh snapshot equals the current values, so only compare old ones
	assign diff = armed_q & ~cls.base_wr &
		((vars != vars_snap) | (frame != frame_snap) | (cp != cp_snap));

	assign changed_now = changed_q | diff;

	always_ff @(posedge clk) begin
		if (rst || u_done) begin
			// end of the ucode sequence drops the tracker
			armed_q <= 1'b0;
			changed_q <= 1'b0;
		end else begin
			armed_q <= armed_now;
			changed_q <= changed_now;
		end
	end

	// base register values at the latest base write
	always_ff @(posedge clk) begin
		if (~u_done && cls.base_wr) begin
			vars_snap <= vars;
			frame_snap <= frame;
			cp_snap <= cp;
		end
	end

	always_comb begin
		viol = '0;
		viol.reg_read = ~u_done & armed_now & changed_now & cls.dc_read;
	end

	// change is only tracked after a base write
	a_changed_armed: assert property (@(posedge clk) disable iff (rst)
		changed_q |-> armed_q);

endmodule

// File: source/stage_rule_check.sv
/*
 pipelined rule checker
 rule 5 across E, C and W, rule 9 one cycle after next-last
*/
`timescale 1ns/1ps

module stage_rule_check (
	input logic clk,
	input logic rst,
	ucode_class_if.check cls,
	input logic u_ref_null_c,
	input logic u_ary_ovf_c,
	input logic gc_trap_c,
	input logic u_ptr_un_eq_c,
	input logic u_done,
	input logic nxt_ucode_last,
	input logic reg_enable,
	input logic u_exception,
	output ucode_mon_pkg::rule_vec_t viol
);

	logic acc_e;
	logic exc_c;
	// access seen last cycle, now in C
	logic acc_c;
	// access plus C exception, now in W
	logic flag_w;
	// next cycle is the last ucode cycle
	logic last_q;

	// s$ or d$ touched in E
	assign acc_e = cls.wt_stk | cls.rd_stk | cls.dc_access;

	// the four C-stage exceptions
	assign exc_c = u_ref_null_c | u_ary_ovf_c | gc_trap_c | u_ptr_un_eq_c;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_c <= 1'b0;
			flag_w <= 1'b0;
			last_q <= 1'b0;
		end else begin
			acc_c <= acc_e;
			flag_w <= acc_c & exc_c;
			// exception cancels the last-cycle marker
			last_q <= nxt_ucode_last & reg_enable & ~u_exception;
		end
	end

	always_comb begin
		viol = '0;
		// rule 5 needs u_done in the W stage
		viol.exc_done = flag_w & ~u_done;
		// rule 9 forbids optop or vars writes in the last cycle
		viol.last_reg = last_q & (cls.optop_wr | cls.vars_wr);
	end

	// a W flag goes back to an E access two cycles and a C exception one cycle earlier
	a_w_from_e: assert property (@(posedge clk) disable iff (rst)
		flag_w |-> $past(acc_e, 2) && $past(exc_c));

endmodule

// File: source/cycle_rule_check.sv
/*
 single-cycle rule checker
 rules 1, 4, 7, 8 and 14, all on the current cycle's inputs
*/
`timescale 1ns/1ps
`include "ucode_mon_settings.svh"

module cycle_rule_check (
	ucode_class_if.check cls,
	input logic [`UM_ADDR_W-1:0] addr_st_wt,
	input logic [`UM_ADDR_W-1:0] addr_st_rd,
	input logic u_exception,
	input logic ie_stall_ucode,
	input logic u_last,
	input logic u_done,
	input logic iu_trap_r,
	input logic ifu_op_valid_r,
	output ucode_mon_pkg::rule_vec_t viol
);

	logic same_addr;

	// stack cache port collision
	assign same_addr = (addr_st_wt == addr_st_rd);

	always_comb begin
		// bits owned by other checkers stay low
		viol = '0;

		// rule 1, read and write hit one s$ entry
		viol.same_addr = cls.wt_stk & cls.rd_stk & same_addr;

		// rule 4, special request needs a d$ read
		viol.special_rd = cls.special_req & ~cls.dc_read;

		// rule 7, no exception while stalled
		viol.stall_exc = ie_stall_ucode & u_exception;

		// rule 8
		viol.last_done = u_last & ~u_done;

		// rule 14, trap and valid opcode exclusive
		viol.trap_op = iu_trap_r & ifu_op_valid_r;
	end

endmodule

// File: source/ucode_field_decode.sv
/*
 microcode field decoder
 turns f01, f02, f03 and f05 into the access classes the checkers use
*/
`timescale 1ns/1ps

module ucode_field_decode (
	input ucode_mon_pkg::f01_t u_f01,
	input ucode_mon_pkg::f02_t u_f02,
	input ucode_mon_pkg::f03_t u_f03,
	input ucode_mon_pkg::f05_t u_f05,
	ucode_class_if.decode cls
);

	// any stack write, special requests included
	assign cls.wt_stk = (u_f01 != ucode_mon_pkg::F01_IDLE);

	// any non-idle f02 reads the stack
	assign cls.rd_stk = (u_f02 != ucode_mon_pkg::F02_IDLE);

	// d$ data written into s$
	assign cls.special_req = (u_f01 == ucode_mon_pkg::F01_WT_DREG_STK) ||
		(u_f01 == ucode_mon_pkg::F01_WT_DREG_STK_M8);

	// array load also reads d$
	assign cls.dc_read = (u_f03 == ucode_mon_pkg::F03_RD_DCACHE) ||
		(u_f03 == ucode_mon_pkg::F03_ARY_LD);

	assign cls.dc_access = (u_f03 != ucode_mon_pkg::F03_IDLE);

	// both optop write flavours
	assign cls.optop_wr = (u_f05 == ucode_mon_pkg::F05_WT_A_OPTOP) ||
		(u_f05 == ucode_mon_pkg::F05_WT_V_OPTOP);

	assign cls.vars_wr = (u_f05 == ucode_mon_pkg::F05_WT_A_VARS);

	// writes that move a base pointer, used by rule 15
	assign cls.base_wr = (u_f05 == ucode_mon_pkg::F05_WT_A_VARS) ||
		(u_f05 == ucode_mon_pkg::F05_WT_A_FRAME) ||
		(u_f05 == ucode_mon_pkg::F05_WT_A_CONST_P);

endmodule

// File: source/ucode_class_if.sv
/*
 decoded microcode access classes, decoder to rule checkers
*/
`timescale 1ns/1ps

interface ucode_class_if;
	// stack cache
	logic wt_stk;
	logic rd_stk;
	logic special_req;
	// data cache
	logic dc_read;
	logic dc_access;
	// register writes
	logic optop_wr;
	logic vars_wr;
	logic base_wr;

	modport decode (output wt_stk, rd_stk, special_req, dc_read, dc_access,
		optop_wr, vars_wr, base_wr);
	modport check (input wt_stk, rd_stk, special_req, dc_read, dc_access,
		optop_wr, vars_wr, base_wr);
endinterface

// File: source/ucode_mon_pkg.sv
/*
 ucode monitor package
 microcode field encodings, rule codes and the violation record
*/
package ucode_mon_pkg;

	// f01, stack write field; 4 to 7 are other stack writes
	typedef enum logic [2:0] {
		F01_IDLE           = 3'd0,
		F01_WT_STK         = 3'd1,
		F01_WT_DREG_STK    = 3'd2,
		F01_WT_DREG_STK_M8 = 3'd3
	} f01_t;

	// f02, stack read field; anything but idle reads
	typedef enum logic [1:0] {
		F02_IDLE = 2'd0
	} f02_t;

	// f03, data cache field
	typedef enum logic [1:0] {
		F03_IDLE      = 2'd0,
		F03_RD_DCACHE = 2'd1,
		F03_WT_DCACHE = 2'd2,
		F03_ARY_LD    = 2'd3
	} f03_t;

	// f05, register write field; 6 and 7 are other registers
	typedef enum logic [2:0] {
		F05_IDLE       = 3'd0,
		F05_WT_A_OPTOP = 3'd1,
		F05_WT_V_OPTOP = 3'd2,
		F05_WT_A_VARS  = 3'd3,
		F05_WT_A_FRAME = 3'd4,
		F05_WT_A_CONST_P = 3'd5
	} f05_t;

	// rule numbers as reported on err_rule
	typedef enum logic [3:0] {
		NONE       = 4'd0,
		SAME_ADDR  = 4'd1,
		SPECIAL_RD = 4'd4,
		EXC_DONE   = 4'd5,
		STALL_EXC  = 4'd7,
		LAST_DONE  = 4'd8,
		LAST_REG   = 4'd9,
		TRAP_OP    = 4'd14,
		REG_READ   = 4'd15
	} rule_t;

	// one bit per kept rule, rule 1 in bit 0
	typedef struct packed {
		logic reg_read;
		logic trap_op;
		logic last_reg;
		logic last_done;
		logic stall_exc;
		logic exc_done;
		logic special_rd;
		logic same_addr;
	} rule_vec_t;

endpackage

// File: source/ucode_mon_settings.svh
/*
 ucode monitor settings
 widths and rule count for the microcode sequencer checker
*/
`ifndef UCODE_MON_SETTINGS_SVH
`define UCODE_MON_SETTINGS_SVH

// stack-cache address width
`define UM_ADDR_W 32

// optop, vars, frame and cp width
`define UM_REG_W 32

// kept rules, one bit each in the violation record
`define UM_RULE_CNT 8

`endif
